// ==== verilog/axi_wb_pkg.sv ====
////////////////////
// Shared encodings for the AXI write to Wishbone bridge
// Burst and response codes follow the AXI4 field values
// Master states fit in two bits
////////////////////

package axi_wb_pkg;

	////////////////////
	// AXI field encodings
	typedef enum logic [1:0]
	{
		FIXED = 2'd0,	// Same address every beat
		INCR  = 2'd1,	// Word address steps by one
		WRAP  = 2'd2	// Handled as INCR here
	} burst_t;

	typedef enum logic [1:0]
	{
		OKAY   = 2'd0,
		SLVERR = 2'd2	// Some beat of the burst saw a bus error
	} resp_t;

	////////////////////
	// Wishbone master states
	typedef enum logic [1:0]
	{
		IDLE,		// cyc low
		BUS,		// stb up, requests going out
		DRAIN,		// stb down, acks still owed
		ERR_FLUSH	// Marking issued beats as failed
	} wb_state_t;

endpackage

// ==== verilog/aw_burst_expander.sv ====
////////////////////
// Turns one accepted AW request into awlen+1 beat entries
// Full-width beats only, awsize is not looked at
// WRAP bursts step like INCR, no wrap boundary applied
// One beat per cycle while the ring reports room
////////////////////

module aw_burst_expander #(
	parameter ID_W   = 6,
	parameter ADDR_W = 28
) (
	input  logic              i_axi_clk,
	input  logic              i_reset,
	// AW channel
	input  logic              i_axi_awvalid,
	output logic              o_axi_awready,
	input  logic [ID_W-1:0]   i_axi_awid,
	input  logic [ADDR_W-1:0] i_axi_awaddr,	// Word address
	input  logic [7:0]        i_axi_awlen,
	input  logic [1:0]        i_axi_awburst,
	// Beat entries into the ring
	input  logic              i_ring_room,
	output logic              o_beat_push,
	output logic [ADDR_W-1:0] o_beat_addr,
	output logic [ID_W-1:0]   o_beat_id,
	output logic              o_beat_last
);

	axi_wb_pkg::burst_t w_burst;
	logic               w_aw_fire;
	logic               r_busy;	// Burst being expanded
	logic               r_incr;	// Address steps per beat
	logic [7:0]         r_len;	// Beats left after this one

	assign w_burst = axi_wb_pkg::burst_t'(i_axi_awburst);
	assign w_aw_fire = i_axi_awvalid && o_axi_awready;

	// Only take a new address once the last burst is fully written out
	assign o_axi_awready = !r_busy && i_ring_room;
	assign o_beat_push   = r_busy && i_ring_room;
	assign o_beat_last   = (r_len == 8'd0);

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
			r_busy <= 1'b0;
		else if (w_aw_fire)
			r_busy <= 1'b1;
		else if (o_beat_push && o_beat_last)
			r_busy <= 1'b0;	// Final entry written
	end

	////////////////////
	// Burst payload
	always_ff @(posedge i_axi_clk)
	begin
		if (w_aw_fire)
		begin
			o_beat_addr <= i_axi_awaddr;
			o_beat_id   <= i_axi_awid;
			r_len       <= i_axi_awlen;
			r_incr      <= (w_burst == axi_wb_pkg::INCR)
				|| (w_burst == axi_wb_pkg::WRAP);
		end
		else if (o_beat_push)
		begin
			r_len       <= r_len - 8'd1;
			o_beat_addr <= o_beat_addr + {{(ADDR_W-1){1'b0}}, r_incr};	// FIXED holds
		end
	end

endmodule

// ==== verilog/write_beat_ring.sv ====
////////////////////
// Circular store of beat address, id, data, strobe and error
// Depth is 2**LGFIFO; pointers carry one extra wrap bit
// Space is only freed when a beat retires to the B stage
// wlast is not compared with the beat count from awlen
// Issue side read is registered, retire side is not
////////////////////

module write_beat_ring #(
	parameter ID_W   = 6,
	parameter ADDR_W = 28,
	parameter DATA_W = 32,
	parameter LGFIFO = 4
) (
	input  logic                i_axi_clk,
	input  logic                i_reset,
	// From the expander
	input  logic                i_beat_push,
	input  logic [ADDR_W-1:0]   i_beat_addr,
	input  logic [ID_W-1:0]     i_beat_id,
	input  logic                i_beat_last,
	output logic                o_ring_room,
	// W channel
	input  logic                i_axi_wvalid,
	output logic                o_axi_wready,
	input  logic [DATA_W-1:0]   i_axi_wdata,
	input  logic [DATA_W/8-1:0] i_axi_wstrb,
	// Wishbone master side
	output logic                o_issue_avail,
	output logic [ADDR_W-1:0]   o_issue_addr,
	output logic [DATA_W-1:0]   o_issue_data,
	output logic [DATA_W/8-1:0] o_issue_sel,
	input  logic                i_issue_take,
	input  logic                i_done_take,
	input  logic                i_done_err,
	// Response side
	output logic                o_retire_avail,
	output logic [ID_W-1:0]     o_retire_id,
	output logic                o_retire_last,
	output logic                o_retire_err,
	input  logic                i_retire_take
);

	localparam DEPTH = 1 << LGFIFO;
	localparam SEL_W = DATA_W / 8;
	localparam AE_W  = ID_W + 1 + ADDR_W;	// {id, last, addr}

	logic [AE_W-1:0]         r_amem [0:DEPTH-1];
	logic [SEL_W+DATA_W-1:0] r_dmem [0:DEPTH-1];
	logic                    r_emem [0:DEPTH-1];

	logic [LGFIFO:0] r_ahead, r_dhead, r_issue, r_done, r_retire;
	logic [LGFIFO:0] w_issue_next;	// Issue pointer after this edge
	logic [LGFIFO:0] w_afill, w_dfill;
	logic            w_wfire;
	logic            r_live;	// Low for the cycle after reset

	assign w_afill = r_ahead - r_retire;
	assign w_dfill = r_dhead - r_retire;
	assign o_ring_room  = r_live && !w_afill[LGFIFO];	// MSB set means full
	assign o_axi_wready = r_live && !w_dfill[LGFIFO];
	assign w_wfire = i_axi_wvalid && o_axi_wready;
	assign w_issue_next = r_issue + {{LGFIFO{1'b0}}, i_issue_take};

	////////////////////
	// Pointers
	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			r_live   <= 1'b0;
			r_ahead  <= '0;
			r_dhead  <= '0;
			r_issue  <= '0;
			r_done   <= '0;
			r_retire <= '0;
			o_issue_avail <= 1'b0;
		end
		else
		begin
			r_live <= 1'b1;
			if (i_beat_push)
				r_ahead <= r_ahead + 1'b1;
			if (w_wfire)
				r_dhead <= r_dhead + 1'b1;
			if (i_done_take)
				r_done <= r_done + 1'b1;
			if (i_retire_take)
				r_retire <= r_retire + 1'b1;
			r_issue <= w_issue_next;
			// Next beat needs both halves already stored
			o_issue_avail <= (w_issue_next != r_ahead) && (w_issue_next != r_dhead);
		end
	end

	// Storage writes, no reset on payload
	always_ff @(posedge i_axi_clk)
	begin
		if (i_beat_push)
			r_amem[r_ahead[LGFIFO-1:0]] <= {i_beat_id, i_beat_last, i_beat_addr};
		if (w_wfire)
			r_dmem[r_dhead[LGFIFO-1:0]] <= {i_axi_wstrb, i_axi_wdata};
		if (i_done_take)
			r_emem[r_done[LGFIFO-1:0]] <= i_done_err;	// Error per beat
	end

	// Registered read, looks ahead past a take
	always_ff @(posedge i_axi_clk)
	begin
		o_issue_addr <= r_amem[w_issue_next[LGFIFO-1:0]][ADDR_W-1:0];
		{o_issue_sel, o_issue_data} <= r_dmem[w_issue_next[LGFIFO-1:0]];
	end

	////////////////////
	// Retire view
	assign o_retire_avail = (r_retire != r_done);
	assign o_retire_id    = r_amem[r_retire[LGFIFO-1:0]][AE_W-1:ADDR_W+1];
	assign o_retire_last  = r_amem[r_retire[LGFIFO-1:0]][ADDR_W];
	assign o_retire_err   = r_emem[r_retire[LGFIFO-1:0]];

endmodule

// ==== verilog/wb_write_master.sv ====
////////////////////
// Pipelined Wishbone write master fed from the beat ring
// Up to 2**LGFIFO beats may be issued but not yet acked
// After an err, owed acks are ignored and every issued
// beat is failed one per cycle before cyc drops
////////////////////

module wb_write_master #(
	parameter ADDR_W = 28,
	parameter DATA_W = 32,
	parameter LGFIFO = 4
) (
	input  logic                i_axi_clk,
	input  logic                i_reset,
	// Ring issue port
	input  logic                i_issue_avail,
	input  logic [ADDR_W-1:0]   i_issue_addr,
	input  logic [DATA_W-1:0]   i_issue_data,
	input  logic [DATA_W/8-1:0] i_issue_sel,
	output logic                o_issue_take,
	output logic                o_done_take,
	output logic                o_done_err,
	// Wishbone
	output logic                o_wb_cyc,
	output logic                o_wb_stb,
	output logic [ADDR_W-1:0]   o_wb_addr,
	output logic [DATA_W-1:0]   o_wb_data,
	output logic [DATA_W/8-1:0] o_wb_sel,
	input  logic                i_wb_stall,
	input  logic                i_wb_ack,
	input  logic                i_wb_err
);

	axi_wb_pkg::wb_state_t r_state;
	logic [LGFIFO:0]       r_pending;	// Taken from ring, not yet done
	logic                  w_flush;
	logic                  w_err;		// Bus error on a live cycle
	logic                  w_complete;	// Ack or err for a request
	logic                  w_load;		// New beat into the stb register

	assign w_flush    = (r_state == axi_wb_pkg::ERR_FLUSH);
	assign w_err      = o_wb_cyc && i_wb_err && !w_flush;
	assign w_complete = o_wb_cyc && (i_wb_ack || i_wb_err) && !w_flush;
	assign w_load     = i_issue_avail && !w_flush && !w_err
		&& (!o_wb_stb || !i_wb_stall);	// Slot empty or being accepted

	assign o_issue_take = w_load;
	assign o_done_take  = w_complete || (w_flush && (r_pending != '0));
	assign o_done_err   = w_flush || w_err;

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			r_state   <= axi_wb_pkg::IDLE;
			r_pending <= '0;
			o_wb_cyc  <= 1'b0;
			o_wb_stb  <= 1'b0;
		end
		else
		begin
			r_pending <= r_pending + {{LGFIFO{1'b0}}, w_load}
				- {{LGFIFO{1'b0}}, o_done_take};
			case (r_state)
			axi_wb_pkg::IDLE:
				if (w_load)
				begin
					o_wb_cyc <= 1'b1;
					o_wb_stb <= 1'b1;
					r_state  <= axi_wb_pkg::BUS;
				end
			axi_wb_pkg::BUS, axi_wb_pkg::DRAIN:
				if (w_err)
				begin
					o_wb_stb <= 1'b0;	// Stop issuing at once
					if (r_pending == 1)
					begin
						o_wb_cyc <= 1'b0;
						r_state  <= axi_wb_pkg::IDLE;
					end
					else
						r_state <= axi_wb_pkg::ERR_FLUSH;
				end
				else if (w_load)
				begin
					o_wb_stb <= 1'b1;	// Back to back
					r_state  <= axi_wb_pkg::BUS;
				end
				else if (r_state == axi_wb_pkg::BUS)
				begin
					if (!i_wb_stall)
					begin
						o_wb_stb <= 1'b0;
						r_state  <= axi_wb_pkg::DRAIN;
					end
				end
				else if (w_complete && (r_pending == 1))
				begin
					o_wb_cyc <= 1'b0;	// Last ack in
					r_state  <= axi_wb_pkg::IDLE;
				end
			default:	// ERR_FLUSH
				if (r_pending <= 1)
				begin
					o_wb_cyc <= 1'b0;
					r_state  <= axi_wb_pkg::IDLE;
				end
			endcase
		end
	end

	// Request payload, follows each load
	always_ff @(posedge i_axi_clk)
	begin
		if (w_load)
		begin
			o_wb_addr <= i_issue_addr;
			o_wb_data <= i_issue_data;
			o_wb_sel  <= i_issue_sel;
		end
	end

endmodule

// ==== verilog/bresp_tracker.sv ====
////////////////////
// Retires done beats in order, one per cycle
// Errors are merged over a burst into one B response
// Retiring pauses while a response waits for bready
////////////////////

module bresp_tracker #(
	parameter ID_W = 6
) (
	input  logic            i_axi_clk,
	input  logic            i_reset,
	// Ring retire port
	input  logic            i_retire_avail,
	input  logic [ID_W-1:0] i_retire_id,
	input  logic            i_retire_last,
	input  logic            i_retire_err,
	output logic            o_retire_take,
	// B channel
	output logic            o_axi_bvalid,
	input  logic            i_axi_bready,
	output logic [ID_W-1:0] o_axi_bid,
	output logic [1:0]      o_axi_bresp
);

	logic w_b_fire;
	logic w_err_base;	// Sticky flag as seen by this beat
	logic r_err;		// Any failed beat so far in this burst

	assign w_b_fire      = o_axi_bvalid && i_axi_bready;
	assign o_retire_take = i_retire_avail && (!o_axi_bvalid || i_axi_bready);
	assign w_err_base    = r_err && !w_b_fire;	// Cleared by B accept

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			o_axi_bvalid <= 1'b0;
			r_err        <= 1'b0;
		end
		else
		begin
			if (w_b_fire)
				o_axi_bvalid <= 1'b0;
			if (o_retire_take)
			begin
				r_err <= w_err_base || i_retire_err;
				if (i_retire_last)
					o_axi_bvalid <= 1'b1;
			end
			else
				r_err <= w_err_base;
		end
	end

	// Response payload, loaded on the last beat
	always_ff @(posedge i_axi_clk)
	begin
		if (o_retire_take && i_retire_last)
		begin
			o_axi_bid   <= i_retire_id;
			o_axi_bresp <= (w_err_base || i_retire_err) ? axi_wb_pkg::SLVERR
				: axi_wb_pkg::OKAY;
		end
	end

endmodule

// ==== verilog/axi_wr_to_wb_top.sv ====
////////////////////
// AXI4 write slave to pipelined Wishbone write master
// No read channels, no narrow bursts, no exclusive access
// Addresses are word addresses on both sides
// Beat count comes from awlen, wlast is not checked
// Reset is active low at the pin, synchronous inside
////////////////////

module axi_wr_to_wb_top #(
	parameter ID_W   = 6,
	parameter ADDR_W = 28,
	parameter DATA_W = 32,
	parameter LGFIFO = 4
) (
	input  logic                i_axi_clk,
	input  logic                i_axi_reset_n,
	// AW channel
	input  logic                i_axi_awvalid,
	output logic                o_axi_awready,
	input  logic [ID_W-1:0]     i_axi_awid,
	input  logic [ADDR_W-1:0]   i_axi_awaddr,
	input  logic [7:0]          i_axi_awlen,
	input  logic [1:0]          i_axi_awburst,
	// W channel
	input  logic                i_axi_wvalid,
	output logic                o_axi_wready,
	input  logic [DATA_W-1:0]   i_axi_wdata,
	input  logic [DATA_W/8-1:0] i_axi_wstrb,
	input  logic                i_axi_wlast,	// Not checked
	// B channel
	output logic                o_axi_bvalid,
	input  logic                i_axi_bready,
	output logic [ID_W-1:0]     o_axi_bid,
	output logic [1:0]          o_axi_bresp,
	// Wishbone
	output logic                o_wb_cyc,
	output logic                o_wb_stb,
	output logic [ADDR_W-1:0]   o_wb_addr,
	output logic [DATA_W-1:0]   o_wb_data,
	output logic [DATA_W/8-1:0] o_wb_sel,
	input  logic                i_wb_stall,
	input  logic                i_wb_ack,
	input  logic                i_wb_err
);

	logic                w_reset;
	// Expander to ring
	logic                w_beat_push, w_beat_last, w_ring_room;
	logic [ADDR_W-1:0]   w_beat_addr;
	logic [ID_W-1:0]     w_beat_id;
	// Ring to master
	logic                w_issue_avail, w_issue_take, w_done_take, w_done_err;
	logic [ADDR_W-1:0]   w_issue_addr;
	logic [DATA_W-1:0]   w_issue_data;
	logic [DATA_W/8-1:0] w_issue_sel;
	// Ring to tracker
	logic                w_retire_avail, w_retire_last, w_retire_err, w_retire_take;
	logic [ID_W-1:0]     w_retire_id;

	assign w_reset = !i_axi_reset_n;

	aw_burst_expander #(.ID_W(ID_W), .ADDR_W(ADDR_W)) u_expander (
		.i_axi_clk(i_axi_clk), .i_reset(w_reset),
		.i_axi_awvalid(i_axi_awvalid), .o_axi_awready(o_axi_awready),
		.i_axi_awid(i_axi_awid), .i_axi_awaddr(i_axi_awaddr),
		.i_axi_awlen(i_axi_awlen), .i_axi_awburst(i_axi_awburst),
		.i_ring_room(w_ring_room), .o_beat_push(w_beat_push),
		.o_beat_addr(w_beat_addr), .o_beat_id(w_beat_id), .o_beat_last(w_beat_last)
	);

	write_beat_ring #(.ID_W(ID_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W), .LGFIFO(LGFIFO))
	u_ring (
		.i_axi_clk(i_axi_clk), .i_reset(w_reset),
		.i_beat_push(w_beat_push), .i_beat_addr(w_beat_addr),
		.i_beat_id(w_beat_id), .i_beat_last(w_beat_last), .o_ring_room(w_ring_room),
		.i_axi_wvalid(i_axi_wvalid), .o_axi_wready(o_axi_wready),
		.i_axi_wdata(i_axi_wdata), .i_axi_wstrb(i_axi_wstrb),
		.o_issue_avail(w_issue_avail), .o_issue_addr(w_issue_addr),
		.o_issue_data(w_issue_data), .o_issue_sel(w_issue_sel),
		.i_issue_take(w_issue_take), .i_done_take(w_done_take), .i_done_err(w_done_err),
		.o_retire_avail(w_retire_avail), .o_retire_id(w_retire_id),
		.o_retire_last(w_retire_last), .o_retire_err(w_retire_err),
		.i_retire_take(w_retire_take)
	);

	wb_write_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LGFIFO(LGFIFO)) u_master (
		.i_axi_clk(i_axi_clk), .i_reset(w_reset),
		.i_issue_avail(w_issue_avail), .i_issue_addr(w_issue_addr),
		.i_issue_data(w_issue_data), .i_issue_sel(w_issue_sel),
		.o_issue_take(w_issue_take), .o_done_take(w_done_take), .o_done_err(w_done_err),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_err(i_wb_err)
	);

	bresp_tracker #(.ID_W(ID_W)) u_tracker (
		.i_axi_clk(i_axi_clk), .i_reset(w_reset),
		.i_retire_avail(w_retire_avail), .i_retire_id(w_retire_id),
		.i_retire_last(w_retire_last), .i_retire_err(w_retire_err),
		.o_retire_take(w_retire_take),
		.o_axi_bvalid(o_axi_bvalid), .i_axi_bready(i_axi_bready),
		.o_axi_bid(o_axi_bid), .o_axi_bresp(o_axi_bresp)
	);

endmodule

// ==== tb/axi_wr_to_wb_asserts.sv ====
////////////////////
// Handshake rules on the Wishbone master side
// Bound to wb_write_master, sees its state register
////////////////////

module axi_wr_to_wb_asserts #(
	parameter ADDR_W = 28,
	parameter DATA_W = 32
) (
	input logic                    i_axi_clk,
	input logic                    i_reset,
	input logic                    i_wb_cyc,
	input logic                    i_wb_stb,
	input logic [ADDR_W-1:0]       i_wb_addr,
	input logic [DATA_W-1:0]       i_wb_data,
	input logic [DATA_W/8-1:0]     i_wb_sel,
	input logic                    i_wb_stall,
	input axi_wb_pkg::wb_state_t   i_state
);
	timeunit 1ns;
	timeprecision 100ps;

	a_stb_in_cyc: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		i_wb_stb |-> i_wb_cyc) else $error("stb high outside a cycle");

	// Stalled request must not change
	a_hold_payload: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		(i_wb_stb && i_wb_stall) |=> ($stable(i_wb_addr) && $stable(i_wb_data)
		&& $stable(i_wb_sel))) else $error("request changed while stalled");

	a_reset_cyc: assert property (@(posedge i_axi_clk)
		i_reset |=> !i_wb_cyc) else $error("cyc high after reset");

	////////////////////
	// Error flush
	a_flush_no_stb: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		(i_state == axi_wb_pkg::ERR_FLUSH) |-> !i_wb_stb)
		else $error("stb high during error flush");

endmodule

// ==== tb/tb_axi_wr_to_wb.sv ====
////////////////////
// Directed tests for the AXI write to Wishbone bridge
// Widths fixed at the top-level defaults
// Wishbone slave stalls and ack delays come from a 16-bit LFSR
// Inputs change on the falling edge, outputs read there too
// Run stops at the first mismatch or at the cycle limit
////////////////////

module tb_axi_wr_to_wb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam ID_W   = 6;
	localparam ADDR_W = 28;
	localparam DATA_W = 32;
	localparam LGFIFO = 4;
	localparam SEL_W  = DATA_W / 8;
	localparam REQ_W  = ADDR_W + DATA_W + SEL_W;	// {addr, data, sel}
	localparam TIMEOUT_CYCLES = 4000;	// All tests take a few hundred cycles

	logic                i_axi_clk = 1'b0;
	logic                i_axi_reset_n;
	logic                i_axi_awvalid, o_axi_awready;
	logic [ID_W-1:0]     i_axi_awid;
	logic [ADDR_W-1:0]   i_axi_awaddr;
	logic [7:0]          i_axi_awlen;
	logic [1:0]          i_axi_awburst;
	logic                i_axi_wvalid, o_axi_wready, i_axi_wlast;
	logic [DATA_W-1:0]   i_axi_wdata;
	logic [SEL_W-1:0]    i_axi_wstrb;
	logic                o_axi_bvalid, i_axi_bready;
	logic [ID_W-1:0]     o_axi_bid;
	logic [1:0]          o_axi_bresp;
	logic                o_wb_cyc, o_wb_stb;
	logic [ADDR_W-1:0]   o_wb_addr;
	logic [DATA_W-1:0]   o_wb_data;
	logic [SEL_W-1:0]    o_wb_sel;
	logic                i_wb_stall, i_wb_ack, i_wb_err;

	// Scoreboard
	logic [REQ_W-1:0]  exp_req [$];	// Requests still to be seen on the bus
	logic [ID_W+1:0]   exp_b [$];	// {id, resp} in issue order
	logic [REQ_W-1:0]  wb_owed [$];	// Accepted, not yet answered

	// Slave model controls
	logic [15:0] r_lfsr;
	logic        r_bit;
	logic        r_random;		// Random stall and ack delay
	logic        r_check_req;	// Compare requests against exp_req
	logic        r_abandon;		// Err sent, wait for cyc to drop
	logic        r_hold_b;		// Keep bready low
	int          r_err_at;		// Response number that gets err
	int          r_resp_cnt;
	int          r_stall_cycles;
	int          r_cycles;

	axi_wr_to_wb_top #(
		.ID_W(ID_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W), .LGFIFO(LGFIFO)
	) DUT (.*);

	bind wb_write_master axi_wr_to_wb_asserts #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_asserts (
		.i_axi_clk(i_axi_clk), .i_reset(i_reset),
		.i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb), .i_wb_addr(o_wb_addr),
		.i_wb_data(o_wb_data), .i_wb_sel(o_wb_sel), .i_wb_stall(i_wb_stall),
		.i_state(r_state)
	);

	always #50 i_axi_clk = ~i_axi_clk;

	////////////////////
	// Helpers
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic take_bit(output logic bit_out);
		r_lfsr  = lfsr_next(r_lfsr);
		bit_out = r_lfsr[0];	// One step per bit
	endtask

	// Distinct word per id and beat
	function automatic logic [DATA_W-1:0] beat_data(input logic [ID_W-1:0] id, input int beat);
		return {4'hA, 2'b00, id, 4'h5, beat[7:0], 8'h3C};
	endfunction

	// Changed on the rising edge, read by the slave on the falling one
	task automatic set_slave(input logic random, input logic check, input int err_offset);
		@(posedge i_axi_clk);
		r_random    = random;
		r_check_req = check;
		r_err_at    = (err_offset < 0) ? -1 : r_resp_cnt + err_offset;
		@(negedge i_axi_clk);
	endtask

	////////////////////
	// AXI master model
	task automatic send_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
		input logic [7:0] len, input axi_wb_pkg::burst_t burst,
		input logic [SEL_W-1:0] strb, input axi_wb_pkg::resp_t resp);
		logic [ADDR_W-1:0] step;
		exp_b.push_back({id, resp});
		for (int i = 0; i <= len; i++)
		begin
			step = '0;	// FIXED stays put
			if (burst != axi_wb_pkg::FIXED)
				step = i;
			if (r_check_req)
				exp_req.push_back({addr + step, beat_data(id, i), strb});
		end
		i_axi_awvalid = 1'b1;
		i_axi_awid    = id;
		i_axi_awaddr  = addr;
		i_axi_awlen   = len;
		i_axi_awburst = burst;
		while (!o_axi_awready)
		begin
			r_stall_cycles++;
			@(negedge i_axi_clk);
		end
		@(negedge i_axi_clk);	// AW taken on the edge between
		i_axi_awvalid = 1'b0;
		for (int i = 0; i <= len; i++)
		begin
			i_axi_wvalid = 1'b1;
			i_axi_wdata  = beat_data(id, i);
			i_axi_wstrb  = strb;
			i_axi_wlast  = (i == len);
			while (!o_axi_wready)
			begin
				r_stall_cycles++;
				@(negedge i_axi_clk);
			end
			@(negedge i_axi_clk);
		end
		i_axi_wvalid = 1'b0;
		i_axi_wlast  = 1'b0;
	endtask

	task automatic wait_all_done();
		while (exp_b.size() != 0)
			@(posedge i_axi_clk);
		@(negedge i_axi_clk);
		check_value("expected Wishbone requests left", exp_req.size(), 0);
	endtask

	////////////////////
	// Wishbone slave model
	task automatic accept_request();
		logic [REQ_W-1:0] exp;
		wb_owed.push_back({o_wb_addr, o_wb_data, o_wb_sel});
		if (r_check_req)
		begin
			if (exp_req.size() == 0)
				fail_run("Wishbone request seen with no beat expected");
			exp = exp_req.pop_front();
			check_value("o_wb_addr", o_wb_addr, exp[REQ_W-1:DATA_W+SEL_W]);
			check_value("o_wb_data", o_wb_data, exp[DATA_W+SEL_W-1:SEL_W]);
			check_value("o_wb_sel", o_wb_sel, exp[SEL_W-1:0]);
		end
	endtask

	always @(negedge i_axi_clk)
	begin
		i_wb_ack   = 1'b0;
		i_wb_err   = 1'b0;
		i_wb_stall = 1'b0;
		if (!o_wb_cyc)
		begin
			wb_owed.delete();	// Cycle over, nothing owed
			r_abandon = 1'b0;
		end
		else if (!r_abandon)
		begin
			// Answer the oldest request first
			r_bit = 1'b1;
			if (wb_owed.size() != 0 && r_random)
				take_bit(r_bit);
			if (wb_owed.size() != 0 && r_bit)
			begin
				if (r_resp_cnt == r_err_at)
				begin
					i_wb_err  = 1'b1;
					r_abandon = 1'b1;	// Master fails the rest itself
					wb_owed.delete();
				end
				else
				begin
					i_wb_ack = 1'b1;
					void'(wb_owed.pop_front());
				end
				r_resp_cnt++;
			end
			if (!r_abandon)
			begin
				if (r_random)
				begin
					take_bit(r_bit);
					i_wb_stall = r_bit;
				end
				if (o_wb_stb && !i_wb_stall)
					accept_request();	// Taken on the next rising edge
			end
		end
	end

	// B channel, bvalid is a flop so stable here
	always @(negedge i_axi_clk)
	begin
		i_axi_bready = !r_hold_b;
		if (o_axi_bvalid && i_axi_bready)
		begin
			if (exp_b.size() == 0)
				fail_run("B response arrived with no burst outstanding");
			check_value("o_axi_bid", o_axi_bid, exp_b[0][ID_W+1:2]);
			check_value("o_axi_bresp", o_axi_bresp, exp_b[0][1:0]);
			void'(exp_b.pop_front());
		end
	end

	always @(posedge i_axi_clk)
	begin
		r_cycles++;
		if (r_cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout: DUT still busy after %0d cycles", r_cycles));
	end

	////////////////////
	// Tests
	task automatic test_single_beat();
		send_burst(6'h05, 28'h0001234, 8'd0, axi_wb_pkg::INCR, 4'h6, axi_wb_pkg::OKAY);
		wait_all_done();
	endtask

	task automatic test_incr_burst();
		send_burst(6'h11, 28'h0100000, 8'd7, axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::OKAY);
		wait_all_done();
	endtask

	task automatic test_fixed_burst();
		send_burst(6'h22, 28'h0200040, 8'd3, axi_wb_pkg::FIXED, 4'hF, axi_wb_pkg::OKAY);
		wait_all_done();
	endtask

	task automatic test_stalls_and_b_backpressure();
		set_slave(1'b1, 1'b1, -1);
		send_burst(6'h01, 28'h0400000, 8'd5, axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::OKAY);
		send_burst(6'h02, 28'h0400100, 8'd2, axi_wb_pkg::FIXED, 4'h3, axi_wb_pkg::OKAY);
		send_burst(6'h03, 28'h0400200, 8'd10, axi_wb_pkg::WRAP, 4'hF, axi_wb_pkg::OKAY);
		wait_all_done();
		set_slave(1'b0, 1'b1, -1);
		@(posedge i_axi_clk);
		r_hold_b = 1'b1;
		@(negedge i_axi_clk);
		r_stall_cycles = 0;
		fork
			begin
				repeat (40) @(posedge i_axi_clk);
				r_hold_b = 1'b0;
			end
			// 32 beats against a 16 entry ring
			for (int b = 0; b < 4; b++)
				send_burst(6'h08 + b, 28'h0500000 + 28'h100 * b, 8'd7,
					axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::OKAY);
		join
		wait_all_done();
		check_value("awready/wready stall seen", r_stall_cycles != 0, 1);
	endtask

	task automatic test_error_burst();
		set_slave(1'b0, 1'b0, 1);	// Second beat gets err
		send_burst(6'h2A, 28'h0300000, 8'd3, axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::SLVERR);
		wait_all_done();
		set_slave(1'b0, 1'b1, -1);
		send_burst(6'h15, 28'h0300100, 8'd2, axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::OKAY);
		wait_all_done();
	endtask

	task automatic test_back_to_back();
		set_slave(1'b1, 1'b1, -1);
		send_burst(6'h30, 28'h0600000, 8'd1, axi_wb_pkg::INCR, 4'hF, axi_wb_pkg::OKAY);
		send_burst(6'h31, 28'h0600010, 8'd4, axi_wb_pkg::INCR, 4'hC, axi_wb_pkg::OKAY);
		send_burst(6'h32, 28'h0600020, 8'd2, axi_wb_pkg::FIXED, 4'hF, axi_wb_pkg::OKAY);
		send_burst(6'h33, 28'h0600030, 8'd0, axi_wb_pkg::INCR, 4'h1, axi_wb_pkg::OKAY);
		wait_all_done();
		set_slave(1'b0, 1'b1, -1);
	endtask

	initial
	begin
		i_axi_reset_n = 1'b0;
		i_axi_awvalid = 1'b0;
		i_axi_awid    = '0;
		i_axi_awaddr  = '0;
		i_axi_awlen   = '0;
		i_axi_awburst = '0;
		i_axi_wvalid  = 1'b0;
		i_axi_wdata   = '0;
		i_axi_wstrb   = '0;
		i_axi_wlast   = 1'b0;
		i_axi_bready  = 1'b0;
		i_wb_stall    = 1'b0;
		i_wb_ack      = 1'b0;
		i_wb_err      = 1'b0;
		r_lfsr        = 16'd1518;
		r_random      = 1'b0;
		r_check_req   = 1'b1;
		r_abandon     = 1'b0;
		r_hold_b      = 1'b0;
		r_err_at      = -1;
		r_resp_cnt    = 0;
		r_stall_cycles = 0;
		r_cycles      = 0;
		repeat (8) @(negedge i_axi_clk);
		i_axi_reset_n = 1'b1;
		// Still the reset state here
		check_value("o_axi_awready", o_axi_awready, 0);
		check_value("o_axi_wready", o_axi_wready, 0);
		check_value("o_axi_bvalid", o_axi_bvalid, 0);
		check_value("o_wb_cyc", o_wb_cyc, 0);
		check_value("o_wb_stb", o_wb_stb, 0);
		@(negedge i_axi_clk);
		check_value("o_axi_awready", o_axi_awready, 1);
		check_value("o_axi_wready", o_axi_wready, 1);
		test_single_beat();
		test_incr_burst();
		test_fixed_burst();
		test_stalls_and_b_backpressure();
		test_error_burst();
		test_back_to_back();
		repeat (4) @(negedge i_axi_clk);
		check_value("o_axi_bvalid", o_axi_bvalid, 0);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
verilog/axi_wb_pkg.sv
verilog/aw_burst_expander.sv
verilog/write_beat_ring.sv
verilog/wb_write_master.sv
verilog/bresp_tracker.sv
verilog/axi_wr_to_wb_top.sv
tb/axi_wr_to_wb_asserts.sv
tb/tb_axi_wr_to_wb.sv
